// ==== Bender.yml ====
package:
  name: upi_periph

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/upi_bus_pkg.sv
      - source/upi_port_pkg.sv
      - source/upi_host_if.sv
      - source/upi_cmd_engine.sv
      - source/upi_port_cell.sv
      - source/upi_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/upi_clk_gen.sv
      - verif/upi_tb.sv

// ==== filelist.f ====
+incdir+source
source/upi_bus_pkg.sv
source/upi_port_pkg.sv
source/upi_host_if.sv
source/upi_cmd_engine.sv
source/upi_port_cell.sv
source/upi_top.sv
verif/upi_clk_gen.sv
verif/upi_tb.sv

// ==== source/upi_bus_pkg.sv ====
// Host bus command set
package upi_bus_pkg;

    // Opcodes, low nibble of port commands holds the port number
    typedef enum logic [7:0] {
        CMD_WR_PORT = 8'h10,
        CMD_RD_PORT = 8'h20,
        CMD_T0_CLR  = 8'h30,
        CMD_T0_SET  = 8'h31
    } upi_cmd_e;

    // Keeps the opcode family of a command byte
    localparam logic [7:0] CMD_FAM_MASK = 8'hF0;

    // Status register layout, other bits read 0
    // Output buffer full
    localparam int unsigned ST_OBF = 0;
    // Input buffer full
    localparam int unsigned ST_IBF = 1;
    // Error on bad command or stray data
    localparam int unsigned ST_F0  = 2;
    // a0 of the last accepted write
    localparam int unsigned ST_F1  = 3;

endpackage

// ==== source/upi_cfg.svh ====
// UPI build configuration
`ifndef UPI_CFG_SVH
`define UPI_CFG_SVH

// Host bus and port width
`define UPI_DATA_W 8

// Port cells behind the engine, 4 also supported
`define UPI_NUM_PORTS 2

// Flops between a port pin and its read value
`define UPI_SYNC_DEPTH 2

`endif

// ==== source/upi_cmd_engine.sv ====
// Fixed-function command engine
`timescale 1ns/1ps
`include "upi_cfg.svh"

module upi_cmd_engine (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ibf_i,
    input  logic                       obf_i,
    input  upi_port_pkg::port_val_t    in_byte_i,
    input  logic                       in_is_cmd_i,
    output logic                       take_o,
    output logic                       set_f0_o,
    output logic                       load_out_o,
    output upi_port_pkg::port_idx_t    sel_port_o,
    output logic [`UPI_NUM_PORTS-1:0]  wr_en_o,
    output upi_port_pkg::port_val_t    wr_data_o,
    output logic                       t0_o
);
    import upi_bus_pkg::*;
    import upi_port_pkg::*;

    typedef enum logic {
        IDLE,
        WAIT_DATA
    } state_e;

    state_e     state_q;
    state_e     state_d;
    port_idx_t  pend_q;
    port_idx_t  pend_d;
    logic       t0_q;
    logic       t0_d;
    logic [7:0] cmd_fam;
    logic [3:0] cmd_port;
    logic       port_ok;

    assign cmd_fam  = in_byte_i & CMD_FAM_MASK;
    assign cmd_port = in_byte_i[3:0];
    assign port_ok  = (cmd_port < `UPI_NUM_PORTS);

    // Decode acts in the cycle after IBF rises
    always_comb begin
        take_o     = 1'b0;
        set_f0_o   = 1'b0;
        load_out_o = 1'b0;
        wr_en_o    = '0;
        state_d    = state_q;
        pend_d     = pend_q;
        t0_d       = t0_q;
        if (ibf_i && in_is_cmd_i) begin
            // Any command drops a pending write
            case (cmd_fam)
                CMD_WR_PORT: begin
                    take_o   = 1'b1;
                    set_f0_o = !port_ok;
                    state_d  = port_ok ? WAIT_DATA : IDLE;
                    pend_d   = port_idx_t'(cmd_port);
                end
                CMD_RD_PORT: begin
                    if (!port_ok) begin
                        take_o   = 1'b1;
                        set_f0_o = 1'b1;
                        state_d  = IDLE;
                    end else if (!obf_i) begin
                        // Stalls with IBF set until the host reads data
                        take_o     = 1'b1;
                        load_out_o = 1'b1;
                        state_d    = IDLE;
                    end
                end
                CMD_T0_CLR: begin
                    take_o  = 1'b1;
                    state_d = IDLE;
                    if (in_byte_i == CMD_T0_SET) begin
                        t0_d = 1'b1;
                    end else if (in_byte_i == CMD_T0_CLR) begin
                        t0_d = 1'b0;
                    end else begin
                        set_f0_o = 1'b1;
                    end
                end
                default: begin
                    take_o   = 1'b1;
                    set_f0_o = 1'b1;
                    state_d  = IDLE;
                end
            endcase
        end else if (ibf_i) begin
            take_o = 1'b1;
            if (state_q == WAIT_DATA) begin
                wr_en_o[pend_q] = 1'b1;
                state_d         = IDLE;
            end else begin
                // Data with nothing to go to
                set_f0_o = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            pend_q  <= '0;
            t0_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            pend_q  <= pend_d;
            t0_q    <= t0_d;
        end
    end

    // Shared write bus where the enables pick the cell
    assign wr_data_o  = in_byte_i;
    assign sel_port_o = port_idx_t'(cmd_port);
    assign t0_o       = t0_q;

    // Host buffer keeps a byte until the engine takes it
    a_byte_held: assert property (@(posedge clk) disable iff (rst)
        ibf_i && !take_o |=> ibf_i && $stable(in_byte_i) && $stable(in_is_cmd_i))
        else $error("input byte lost before it was taken");

endmodule

// ==== source/upi_host_if.sv ====
// Host data bus buffer
`timescale 1ns/1ps
`include "upi_cfg.svh"

module upi_host_if (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    a0_i,
    input  logic                    wr_i,
    input  logic                    rd_i,
    input  upi_port_pkg::port_val_t din_i,
    input  logic                    take_i,
    input  logic                    set_f0_i,
    input  logic                    load_out_i,
    input  upi_port_pkg::port_idx_t sel_port_i,
    input  upi_port_pkg::port_val_t rd_val_i [`UPI_NUM_PORTS],
    output upi_port_pkg::port_val_t dout_o,
    output logic                    ibf_o,
    output logic                    obf_o,
    output upi_port_pkg::port_val_t in_byte_o,
    output logic                    in_is_cmd_o
);
    import upi_bus_pkg::*;
    import upi_port_pkg::*;

    logic      ibf_q;
    logic      obf_q;
    logic      f0_q;
    logic      f1_q;
    port_val_t in_q;
    port_val_t out_q;
    port_val_t status;
    logic      wr_acc;
    logic      rd_data;

    // Writes while the input buffer is full are lost
    assign wr_acc  = wr_i && !ibf_q;
    // Only a data read drains the output buffer
    assign rd_data = rd_i && !a0_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            ibf_q <= 1'b0;
            obf_q <= 1'b0;
            f0_q  <= 1'b0;
            f1_q  <= 1'b0;
            out_q <= '0;
        end else begin
            // A write and a take never meet on the input side
            if (wr_acc) begin
                ibf_q <= 1'b1;
                f1_q  <= a0_i;
            end else if (take_i) begin
                ibf_q <= 1'b0;
            end
            // F0 reports on the latest byte only
            if (set_f0_i) begin
                f0_q <= 1'b1;
            end else if (wr_acc) begin
                f0_q <= 1'b0;
            end
            // Port value capture wins over a drain
            if (load_out_i) begin
                out_q <= rd_val_i[sel_port_i];
                obf_q <= 1'b1;
            end else if (rd_data) begin
                obf_q <= 1'b0;
            end
        end
    end

    // Input byte held while IBF is set
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            in_q <= din_i;
        end
    end

    always_comb begin
        status         = '0;
        status[ST_OBF] = obf_q;
        status[ST_IBF] = ibf_q;
        status[ST_F0]  = f0_q;
        status[ST_F1]  = f1_q;
    end

    // Host read mux gives status when a0 is high
    assign dout_o      = a0_i ? status : out_q;
    assign ibf_o       = ibf_q;
    assign obf_o       = obf_q;
    assign in_byte_o   = in_q;
    assign in_is_cmd_o = f1_q;

    // Engine must only consume a byte that is already held
    a_no_take_on_write: assert property (@(posedge clk) disable iff (rst)
        !(take_i && wr_acc))
        else $error("take and host write accepted together");

    // Engine holds port reads until the host drained the buffer
    a_no_load_when_full: assert property (@(posedge clk) disable iff (rst)
        load_out_i |-> !obf_q)
        else $error("load_out while OBF set");

endmodule

// ==== source/upi_port_cell.sv ====
// Quasi-bidirectional port cell
`timescale 1ns/1ps
`include "upi_cfg.svh"

module upi_port_cell (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_en_i,
    input  upi_port_pkg::port_val_t wr_data_i,
    input  upi_port_pkg::port_val_t pin_i,
    output upi_port_pkg::port_val_t pin_o,
    output upi_port_pkg::port_val_t rd_val_o
);
    import upi_port_pkg::*;

    port_val_t latch_q;
    port_val_t sync_q [`UPI_SYNC_DEPTH];

    // Idle high so the outside can pull pins low
    always_ff @(posedge clk) begin
        if (rst) begin
            latch_q <= '1;
        end else if (wr_en_i) begin
            latch_q <= wr_data_i;
        end
    end

    // Pins are asynchronous to clk
    always_ff @(posedge clk) begin
        sync_q[0] <= pin_i;
        for (int i = 1; i < `UPI_SYNC_DEPTH; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    assign pin_o = latch_q;

    // Either side driving low wins
    assign rd_val_o = sync_q[`UPI_SYNC_DEPTH-1] & latch_q;

endmodule

// ==== source/upi_port_pkg.sv ====
// UPI port types
`include "upi_cfg.svh"

package upi_port_pkg;

    // At least one bit, even with a single port
    localparam int PORT_IDX_W = (`UPI_NUM_PORTS > 1) ? $clog2(`UPI_NUM_PORTS) : 1;

    // Selects one port cell
    typedef logic [PORT_IDX_W-1:0] port_idx_t;

    // Value on a port, same width as the host bus
    typedef logic [`UPI_DATA_W-1:0] port_val_t;

endpackage

// ==== source/upi_top.sv ====
// UPI peripheral top level
`timescale 1ns/1ps
`include "upi_cfg.svh"

module upi_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    a0_i,
    input  logic                    wr_i,
    input  logic                    rd_i,
    input  upi_port_pkg::port_val_t din_i,
    input  upi_port_pkg::port_val_t p_din_i [`UPI_NUM_PORTS],
    output upi_port_pkg::port_val_t dout_o,
    output upi_port_pkg::port_val_t p_dout_o [`UPI_NUM_PORTS],
    output logic                    t0_o
);
    import upi_port_pkg::*;

    logic                      ibf;
    logic                      obf;
    logic                      in_is_cmd;
    logic                      take;
    logic                      set_f0;
    logic                      load_out;
    port_val_t                 in_byte;
    port_val_t                 wr_data;
    port_idx_t                 sel_port;
    logic [`UPI_NUM_PORTS-1:0] wr_en;
    port_val_t                 rd_val [`UPI_NUM_PORTS];

    upi_host_if u_host (
        .clk         ( clk       ),
        .rst         ( rst       ),
        .a0_i        ( a0_i      ),
        .wr_i        ( wr_i      ),
        .rd_i        ( rd_i      ),
        .din_i       ( din_i     ),
        .take_i      ( take      ),
        .set_f0_i    ( set_f0    ),
        .load_out_i  ( load_out  ),
        .sel_port_i  ( sel_port  ),
        .rd_val_i    ( rd_val    ),
        .dout_o      ( dout_o    ),
        .ibf_o       ( ibf       ),
        .obf_o       ( obf       ),
        .in_byte_o   ( in_byte   ),
        .in_is_cmd_o ( in_is_cmd )
    );

    upi_cmd_engine u_engine (
        .clk         ( clk       ),
        .rst         ( rst       ),
        .ibf_i       ( ibf       ),
        .obf_i       ( obf       ),
        .in_byte_i   ( in_byte   ),
        .in_is_cmd_i ( in_is_cmd ),
        .take_o      ( take      ),
        .set_f0_o    ( set_f0    ),
        .load_out_o  ( load_out  ),
        .sel_port_o  ( sel_port  ),
        .wr_en_o     ( wr_en     ),
        .wr_data_o   ( wr_data   ),
        .t0_o        ( t0_o      )
    );

    // One cell per port, all on the shared write bus
    for (genvar i = 0; i < `UPI_NUM_PORTS; i++) begin : g_port
        upi_port_cell u_cell (
            .clk       ( clk         ),
            .rst       ( rst         ),
            .wr_en_i   ( wr_en[i]    ),
            .wr_data_i ( wr_data     ),
            .pin_i     ( p_din_i[i]  ),
            .pin_o     ( p_dout_o[i] ),
            .rd_val_o  ( rd_val[i]   )
        );
    end

endmodule

// ==== verif/upi_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module upi_clk_gen (
    output logic clk_o,
    output logic rst_o
);
    // 10 ns period
    localparam int HALF_PERIOD = 5;
    localparam int RST_CYCLES  = 5;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// ==== verif/upi_tb.sv ====
// UPI trace-driven testbench
`timescale 1ns/1ps
`include "upi_cfg.svh"

module upi_tb;
    import upi_bus_pkg::*;

    // Cycles a write may take to drain the input buffer
    localparam int POLL_LIMIT    = 20;
    localparam int WDOG_PER_LINE = 50;
    // Pins settle through the synchronizer before a read command
    localparam int PIN_SETTLE    = 4;

    logic       clk;
    logic       rst;
    logic       a0;
    logic       wr;
    logic       rd;
    logic [7:0] din;
    logic [7:0] dout;
    logic [7:0] p_din  [`UPI_NUM_PORTS];
    logic [7:0] p_dout [`UPI_NUM_PORTS];
    logic       t0;

    string lines [$];
    bit    loaded       = 1'b0;
    int    errors       = 0;
    int    checks       = 0;
    int    test_errors  = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    string test_name    = "";

    upi_clk_gen u_clk (
        .clk_o ( clk ),
        .rst_o ( rst )
    );

    upi_top DUT (
        .clk      ( clk    ),
        .rst      ( rst    ),
        .a0_i     ( a0     ),
        .wr_i     ( wr     ),
        .rd_i     ( rd     ),
        .din_i    ( din    ),
        .p_din_i  ( p_din  ),
        .dout_o   ( dout   ),
        .p_dout_o ( p_dout ),
        .t0_o     ( t0     )
    );

    task automatic compare_value(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s is %02h, expected %02h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // One-cycle write strobe sampled on the rising edge in between
    task automatic host_write(input logic a0_v, input logic [7:0] data);
        @(negedge clk);
        a0  = a0_v;
        din = data;
        wr  = 1'b1;
        @(negedge clk);
        wr  = 1'b0;
        a0  = 1'b0;
    endtask

    // Combinational dout sampled well before the next rising edge
    task automatic host_read(input logic a0_v, output logic [7:0] data);
        @(negedge clk);
        a0 = a0_v;
        rd = 1'b1;
        #1;
        data = dout;
        @(negedge clk);
        rd = 1'b0;
        a0 = 1'b0;
    endtask

    // Status peek with a0 high and no read strobe
    task automatic wait_ibf_clear();
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < POLL_LIMIT) begin
            @(negedge clk);
            a0 = 1'b1;
            #1;
            done = !dout[ST_IBF];
            cycles++;
        end
        if (!done) begin
            $display("Engine stalled: IBF still set %0d cycles after a write, at %0t",
                     POLL_LIMIT, $time);
            errors++;
            test_errors++;
        end
    endtask

    // Summary line for the test that just ended
    task automatic close_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errors == 0) begin
                $display("Test %s passed", test_name);
            end else begin
                tests_failed++;
                $display("Test %s failed with %0d errors", test_name, test_errors);
            end
        end
        test_errors = 0;
    endtask

    initial begin : run
        int         fd;
        int         n_args;
        int         arg_a;
        int         arg_b;
        string      line;
        byte        op;
        logic [7:0] got;
        a0  = 1'b0;
        wr  = 1'b0;
        rd  = 1'b0;
        din = '0;
        // Undriven quasi-bidirectional pins float high
        for (int i = 0; i < `UPI_NUM_PORTS; i++) begin
            p_din[i] = '1;
        end
        fd = $fopen("verif/upi_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file verif/upi_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        wait (!rst);
        foreach (lines[n]) begin
            line  = lines[n];
            op    = line.getc(0);
            arg_a = 0;
            arg_b = 0;
            n_args = $sscanf(line.substr(1, line.len() - 1), "%h %h", arg_a, arg_b);
            case (op)
                "#", "\n", "\r", " ": begin
                end
                "N": begin
                    close_test();
                    n_args = $sscanf(line, "N %s", test_name);
                end
                "W": begin
                    host_write(arg_a[0], arg_b[7:0]);
                    wait_ibf_clear();
                end
                // Write left pending for back-pressure
                "Q": host_write(arg_a[0], arg_b[7:0]);
                "I": wait_ibf_clear();
                "R": begin
                    host_read(arg_a[0], got);
                    compare_value(arg_a[0] ? "dout_o (status)" : "dout_o (data)",
                                  got, arg_b[7:0]);
                end
                "S": begin
                    @(negedge clk);
                    p_din[arg_a] = arg_b[7:0];
                    repeat (PIN_SETTLE) @(negedge clk);
                end
                "E": begin
                    @(negedge clk);
                    #1;
                    compare_value($sformatf("p_dout_o[%0d]", arg_a), p_dout[arg_a],
                                  arg_b[7:0]);
                end
                "T": begin
                    @(negedge clk);
                    #1;
                    compare_value("t0_o", {7'b0, t0}, arg_a[7:0]);
                end
                default: begin
                    $display("Unknown trace operation %c on trace line %0d", op, n + 1);
                    errors++;
                    test_errors++;
                end
            endcase
        end
        close_test();
        $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Bound scales with the trace length plus one line for reset
    initial begin : watchdog
        wait (loaded);
        repeat (WDOG_PER_LINE * (lines.size() + 1)) @(posedge clk);
        $display("Watchdog expired, the trace did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== verif/upi_trace.txt ====
# Ops: N name | W a0 byte | Q a0 byte (no IBF wait) | I (wait IBF clear)
# R a0 expected | S port pins | E port latch | T t0, all values hex
N reset_state
R 1 00
R 0 00
E 0 FF
E 1 FF
T 0
N port_write
W 1 11
R 1 08
W 0 5A
R 1 00
E 1 5A
E 0 FF
W 1 10
W 0 C3
E 0 C3
E 1 5A
N wired_and_read
W 1 11
W 0 F0
S 1 3C
W 1 21
R 1 09
R 0 30
R 1 08
N back_pressure
S 0 A5
W 1 20
R 1 09
S 0 7E
Q 1 20
R 1 0B
R 1 0B
R 0 81
I
R 1 09
R 0 42
R 1 08
N t0_and_errors
W 1 31
T 1
W 1 30
T 0
W 1 31
T 1
W 1 40
R 1 0C
W 1 13
R 1 0C
W 1 23
R 1 0C
W 0 77
R 1 04
W 1 32
R 1 0C
T 1
W 1 10
W 1 30
T 0
W 0 99
R 1 04
E 0 C3
E 1 F0
